// File: logic/pipeline_types.sv
package pipeline_types;

    // simplified ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // instruction as delivered by the instruction buffer
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_t     op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        use_imm;
        logic [11:0] imm;
    } inst_t;

    // operands resolved, ready for a lane
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_t     op;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
    } issue_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
    } lane_result_t;

    // also used as the forwarding source into dispatch
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_write_t;

    // per-lane record for the difference test
    typedef struct packed {
        logic        inst_valid;
        logic [31:0] pc;
        logic        rf_wen;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } commit_diff_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                             clk,
    input  logic                             rst_n_i,

    input  pipeline_types::reg_write_t [1:0] write_i,

    input  logic                 [3:0][4:0]  raddr_i,
    output logic                 [3:0][31:0] rdata_o,

    // full register state for the difference test
    output logic                [31:0][31:0] regs_o
);

    logic [31:0][31:0] regs_q;

    // port 1 goes last so it overrides port 0
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (write_i[p].en && write_i[p].addr != 5'd0) begin
                    regs_q[write_i[p].addr] <= write_i[p].data;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata_o[i] = (raddr_i[i] == 5'd0) ? 32'd0 : regs_q[raddr_i[i]];
        end
    end

    assign regs_o = regs_q;

endmodule

// File: logic/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  pipeline_types::issue_t       issue_i,
    output pipeline_types::lane_result_t result_o
);

    logic [31:0] alu_res;
    pipeline_types::lane_result_t payload_q;

    always_comb begin
        case (issue_i.op)
            pipeline_types::ALU_ADD: alu_res = issue_i.a + issue_i.b;
            pipeline_types::ALU_SUB: alu_res = issue_i.a - issue_i.b;
            pipeline_types::ALU_AND: alu_res = issue_i.a & issue_i.b;
            pipeline_types::ALU_OR:  alu_res = issue_i.a | issue_i.b;
            pipeline_types::ALU_XOR: alu_res = issue_i.a ^ issue_i.b;
            // shift amount from the low 5 bits only
            pipeline_types::ALU_SLL: alu_res = issue_i.a << issue_i.b[4:0];
            pipeline_types::ALU_SRL: alu_res = issue_i.a >> issue_i.b[4:0];
            pipeline_types::ALU_SLT: begin
                alu_res = {31'd0, $signed(issue_i.a) < $signed(issue_i.b)};
            end
            default: alu_res = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            payload_q.valid <= 1'b0;
        end else begin
            payload_q.valid <= issue_i.valid;
        end
        payload_q.pc    <= issue_i.pc;
        payload_q.rd    <= issue_i.rd;
        payload_q.wdata <= alu_res;
    end

    assign result_o = payload_q;

endmodule

// File: logic/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    // from instruction buffer
    input  pipeline_types::inst_t      [1:0]       inst_i,

    // regfile read ports, two per slot
    input  logic                       [3:0][31:0] rf_rdata_i,

    // results not yet in the regfile
    input  pipeline_types::reg_write_t [1:0]       fwd_i,

    output logic                       [3:0][4:0]  rf_raddr_o,
    output pipeline_types::issue_t     [1:0]       issue_o,

    // to instruction buffer
    output logic                       [1:0]       send_inst_en_o
);

    logic pair_dep;
    logic [1:0][31:0] src_a;
    logic [1:0][31:0] src_b;

    // lane 1 is checked last so the younger write wins
    function automatic logic [31:0] fwd_sel(
        input logic [4:0] src,
        input logic [31:0] rf_val,
        input pipeline_types::reg_write_t [1:0] fwd
    );
        logic [31:0] val;
        val = rf_val;
        for (int p = 0; p < 2; p++) begin
            if (fwd[p].en && fwd[p].addr != 5'd0 && fwd[p].addr == src) begin
                val = fwd[p].data;
            end
        end
        return val;
    endfunction

    // slot 1 reading slot 0's destination must wait a cycle
    always_comb begin
        pair_dep = 1'b0;
        if (inst_i[0].rd != 5'd0) begin
            if (inst_i[1].rj == inst_i[0].rd) begin
                pair_dep = 1'b1;
            end
            if (!inst_i[1].use_imm && inst_i[1].rk == inst_i[0].rd) begin
                pair_dep = 1'b1;
            end
        end
    end

    assign send_inst_en_o[0] = inst_i[0].valid;
    assign send_inst_en_o[1] = inst_i[0].valid && inst_i[1].valid && !pair_dep;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_raddr_o[2*i]   = inst_i[i].rj;
            rf_raddr_o[2*i+1] = inst_i[i].rk;

            src_a[i] = fwd_sel(inst_i[i].rj, rf_rdata_i[2*i], fwd_i);
            if (inst_i[i].use_imm) begin
                src_b[i] = {{20{inst_i[i].imm[11]}}, inst_i[i].imm};
            end else begin
                src_b[i] = fwd_sel(inst_i[i].rk, rf_rdata_i[2*i+1], fwd_i);
            end

            issue_o[i].valid = send_inst_en_o[i];
            issue_o[i].pc    = inst_i[i].pc;
            issue_o[i].op    = inst_i[i].op;
            issue_o[i].rd    = inst_i[i].rd;
            issue_o[i].a     = src_a[i];
            issue_o[i].b     = src_b[i];
        end
    end

endmodule

// File: logic/commit.sv
`timescale 1ns/1ps

module commit (
    input  logic                               clk,
    input  logic                               rst_n_i,

    // registered lane results
    input  pipeline_types::lane_result_t [1:0] result_i,

    // to regfile and dispatch forwarding
    output pipeline_types::reg_write_t   [1:0] rf_write_o,

    // debug
    output pipeline_types::commit_diff_t [1:0] diff_o,
    output logic                         [63:0] retire_cnt_o
);

    logic [1:0] lane_wen;
    logic       same_rd;
    logic [63:0] retire_cnt_q;
    logic [63:0] retire_inc;

    // r0 is never written
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lane_wen[i] = result_i[i].valid && result_i[i].rd != 5'd0;
        end
    end

    // lane 1 is younger, it wins on a shared destination
    assign same_rd = lane_wen[0] && lane_wen[1] && result_i[0].rd == result_i[1].rd;

    assign rf_write_o[0].en   = lane_wen[0] && !same_rd;
    assign rf_write_o[0].addr = result_i[0].rd;
    assign rf_write_o[0].data = result_i[0].wdata;

    assign rf_write_o[1].en   = lane_wen[1];
    assign rf_write_o[1].addr = result_i[1].rd;
    assign rf_write_o[1].data = result_i[1].wdata;

    // debug shows each lane's own write, even a shadowed one
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            diff_o[i].inst_valid = result_i[i].valid;
            diff_o[i].pc         = result_i[i].pc;
            diff_o[i].rf_wen     = lane_wen[i];
            diff_o[i].rf_wnum    = result_i[i].rd;
            diff_o[i].rf_wdata   = result_i[i].wdata;
        end
    end

    assign retire_inc = {63'd0, result_i[0].valid} + {63'd0, result_i[1].valid};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_cnt_q <= 64'd0;
        end else begin
            retire_cnt_q <= retire_cnt_q + retire_inc;
        end
    end

    assign retire_cnt_o = retire_cnt_q;

endmodule

// File: logic/backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                                clk,
    input  logic                                rst_n_i,

    // from instruction buffer
    input  pipeline_types::inst_t        [1:0]  inst_i,

    // to instruction buffer
    output logic                         [1:0]  send_inst_en_o,

    // debug
    output pipeline_types::commit_diff_t [1:0]  diff_o,
    output logic                         [63:0] retire_cnt_o,
    output logic                  [31:0][31:0]  regs_diff_o
);

    logic [3:0][4:0]  rf_raddr;
    logic [3:0][31:0] rf_rdata;

    pipeline_types::issue_t       [1:0] issue;
    pipeline_types::lane_result_t [1:0] lane_result;
    pipeline_types::reg_write_t   [1:0] rf_write;

    dispatch u_dispatch (
        .inst_i,
        .rf_rdata_i    (rf_rdata),
        .fwd_i         (rf_write),
        .rf_raddr_o    (rf_raddr),
        .issue_o       (issue),
        .send_inst_en_o
    );

    alu_lane u_lane0 (
        .clk,
        .rst_n_i,
        .issue_i (issue[0]),
        .result_o(lane_result[0])
    );

    alu_lane u_lane1 (
        .clk,
        .rst_n_i,
        .issue_i (issue[1]),
        .result_o(lane_result[1])
    );

    commit u_commit (
        .clk,
        .rst_n_i,
        .result_i    (lane_result),
        .rf_write_o  (rf_write),
        .diff_o,
        .retire_cnt_o
    );

    regfile u_regfile (
        .clk,
        .rst_n_i,
        .write_i(rf_write),
        .raddr_i(rf_raddr),
        .rdata_o(rf_rdata),
        .regs_o (regs_diff_o)
    );

endmodule

// File: dv/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    logic                                clk;
    logic                                rst_n_i;
    pipeline_types::inst_t        [1:0]  inst_i;
    logic                         [1:0]  send_inst_en_o;
    pipeline_types::commit_diff_t [1:0]  diff_o;
    logic                         [63:0] retire_cnt_o;
    logic                  [31:0][31:0]  regs_diff_o;

    integer seed = 68318;
    int     errors = 0;
    int     checks = 0;

    // fields of the current stim line, one entry per slot
    int          f_v   [2];
    int          f_op  [2];
    int          f_rd  [2];
    int          f_rj  [2];
    int          f_rk  [2];
    int          f_u   [2];
    int          f_imm [2];
    logic [31:0] f_wd  [2];
    int          f_acc;

    // what the line before should show on diff_o now
    logic [1:0]       prev_acc;
    logic [1:0][31:0] prev_pc;
    logic [1:0][4:0]  prev_rd;
    logic [1:0][31:0] prev_wd;
    logic [31:0]      exp_regs [32];

    backend_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n_i = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n_i = 1'b1;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic drive_slot(input int s, input logic [31:0] pc);
        logic [31:0] rnd;
        rnd = $random(seed);
        inst_i[s].valid   = f_v[s][0];
        inst_i[s].pc      = pc;
        inst_i[s].op      = pipeline_types::alu_op_t'(f_op[s][2:0]);
        inst_i[s].rd      = f_rd[s][4:0];
        inst_i[s].rj      = f_rj[s][4:0];
        inst_i[s].rk      = f_rk[s][4:0];
        inst_i[s].use_imm = f_u[s][0];
        // register forms get filler in the unused immediate
        inst_i[s].imm     = (f_u[s] != 0) ? f_imm[s][11:0] : rnd[11:0];
    endtask

    task automatic check_lane(input int i);
        string p;
        p = $sformatf("diff_o[%0d].", i);
        check_val({p, "inst_valid"}, 64'(diff_o[i].inst_valid), 64'(prev_acc[i]));
        if (prev_acc[i]) begin
            check_val({p, "pc"}, 64'(diff_o[i].pc), 64'(prev_pc[i]));
            check_val({p, "rf_wen"}, 64'(diff_o[i].rf_wen), 64'(prev_rd[i] != 5'd0));
            check_val({p, "rf_wnum"}, 64'(diff_o[i].rf_wnum), 64'(prev_rd[i]));
            check_val({p, "rf_wdata"}, 64'(diff_o[i].rf_wdata), 64'(prev_wd[i]));
        end
    endtask

    initial begin
        int          fd;
        int          cnt;
        int          cycles;
        int          n_acc;
        int          acc_total;
        int          base;
        logic [7:0]  kind;
        logic [31:0] pc_base;
        logic [31:0] rv [4];
        string       line;
        string       rest;

        // lanes must stay idle while reset holds a valid pair
        inst_i          = '0;
        inst_i[0].valid = 1'b1;
        inst_i[0].rd    = 5'd1;
        inst_i[1].valid = 1'b1;
        inst_i[1].rd    = 5'd2;
        prev_acc  = 2'b00;
        acc_total = 0;
        pc_base   = 32'h1c00_0000;
        fd = $fopen("dv/backend_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/backend_stim.txt");
            errors++;
        end

        cycles = 0;
        while (rst_n_i !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (rst_n_i !== 1'b1) begin
            $display("timeout waiting for reset release");
            errors++;
        end
        for (int i = 0; i < 2; i++) begin
            check_val($sformatf("diff_o[%0d].inst_valid", i), 64'(diff_o[i].inst_valid), 64'd0);
            check_val($sformatf("diff_o[%0d].rf_wen", i), 64'(diff_o[i].rf_wen), 64'd0);
        end
        inst_i = '0;
        @(posedge clk);
        #1;

        // one I line per cycle, R lines carry the final register state
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 1) begin
                kind = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                if (kind == "R") begin
                    cnt = $sscanf(rest, "%d %h %h %h %h", base, rv[0], rv[1], rv[2], rv[3]);
                    for (int j = 0; j < 4; j++) begin
                        exp_regs[base + j] = rv[j];
                    end
                end else if (kind == "I") begin
                    cnt = $sscanf(rest, "%d %d %d %d %d %d %h %d %d %d %d %d %d %h %d %h %h",
                                  f_v[0], f_op[0], f_rd[0], f_rj[0], f_rk[0], f_u[0], f_imm[0],
                                  f_v[1], f_op[1], f_rd[1], f_rj[1], f_rk[1], f_u[1], f_imm[1],
                                  f_acc, f_wd[0], f_wd[1]);
                    if (cnt != 17) begin
                        $display("stim line could not be parsed: %s", line);
                        errors++;
                    end
                    drive_slot(0, pc_base);
                    drive_slot(1, pc_base + 32'd4);
                    #2;
                    check_val("send_inst_en_o", 64'(send_inst_en_o), 64'(f_acc));
                    check_lane(0);
                    check_lane(1);
                    prev_acc = f_acc[1:0];
                    for (int i = 0; i < 2; i++) begin
                        prev_pc[i] = pc_base + 32'(4 * i);
                        prev_rd[i] = f_rd[i][4:0];
                        prev_wd[i] = f_wd[i];
                    end
                    n_acc = (f_acc == 3) ? 2 : ((f_acc == 0) ? 0 : 1);
                    acc_total = acc_total + n_acc;
                    // a split pair comes back with slot 1 moved to slot 0
                    pc_base = pc_base + 32'(4 * n_acc);
                    @(posedge clk);
                    #1;
                end
            end
        end

        inst_i = '0;
        #2;
        check_lane(0);
        check_lane(1);
        cycles = 0;
        while ((diff_o[0].inst_valid || diff_o[1].inst_valid) && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (diff_o[0].inst_valid || diff_o[1].inst_valid) begin
            $display("timeout waiting for the pipeline to drain");
            errors++;
        end
        check_val("retire_cnt_o", retire_cnt_o, 64'(acc_total));
        for (int r = 0; r < 32; r++) begin
            check_val($sformatf("regs_diff_o[%0d]", r), 64'(regs_diff_o[r]), 64'(exp_regs[r]));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dv/backend_stim.txt
# I: slot0 (v op rd rj rk use_imm imm) slot1 (same) accept wdata0 wdata1
# op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt; accept 3 both, 1 slot0, 0 none
I 1 0  1  0  0 1 123   1 0  2  0  0 1 7ff   3 00000123 000007ff
I 1 0  3  0  0 1 800   1 0  4  0  0 1 005   3 fffff800 00000005
I 1 1  5  1  2 0 000   1 3  6  3  4 0 000   3 fffff924 fffff805
I 1 4  7  5  1 0 000   1 5  8  4  0 1 003   3 fffff807 00000028
I 1 6  9  3  4 0 000   1 7 10  3  1 0 000   3 07ffffc0 00000001
I 1 0 11  5  6 0 000   1 1 12 11  9 0 000   1 fffff129 00000000
I 1 1 12 11  9 0 000   1 3 13  8  0 1 0f0   3 f7fff169 000000f8
I 1 0 14  1  0 1 001   1 0 14  2  0 1 002   3 00000124 00000801
I 1 0 15 14 12 0 000   1 0  0  1  2 0 000   3 f7fff96a 00000922
I 1 3 16  0 14 0 000   1 4 17 15 16 1 fff   3 00000801 08000695
I 1 5 18 17  4 0 000   1 6 19  3  0 1 021   3 0000d2a0 7ffffc00
I 1 7 20  3  0 1 fff   0 0  0  0  0 0 000   1 00000001 00000000
I 1 0 23  1  0 1 00f   1 4 24  2 23 0 000   1 00000132 00000000
I 1 4 24  2 23 0 000   1 1 21 20 19 0 000   3 000006cd 80000401
I 0 0  0  0  0 0 000   0 0  0  0  0 0 000   0 00000000 00000000
I 1 0  0  1  0 1 055   1 3 25  0  1 0 000   3 00000178 00000123
# R: first register index, then the final values of four registers
R  0 00000000 00000123 000007ff fffff800
R  4 00000005 fffff924 fffff805 fffff807
R  8 00000028 07ffffc0 00000001 fffff129
R 12 f7fff169 000000f8 00000801 f7fff96a
R 16 00000801 08000695 0000d2a0 7ffffc00
R 20 00000001 80000401 00000000 00000132
R 24 000006cd 00000123 00000000 00000000
R 28 00000000 00000000 00000000 00000000

// File: project.f
logic/pipeline_types.sv
logic/regfile.sv
logic/alu_lane.sv
logic/dispatch.sv
logic/commit.sv
logic/backend_top.sv
dv/backend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module backend_tb -o sim_backend -f project.f

./obj_dir/sim_backend | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
